// ==== mic_echo_pkg.sv ====
package mic_echo_pkg;

  localparam int AUDIO_W      = 16;
  localparam int SUM_W        = AUDIO_W + 2;   // headroom for filter and echo sums
  localparam int FRAME_CYCLES = 2048;          // one 48 kHz sample period
  localparam int BCLK_DIV     = 32;
  localparam int FRAME_W      = $clog2(FRAME_CYCLES);
  localparam int BCLK_W       = $clog2(BCLK_DIV);
  localparam int SLOT_W       = FRAME_W - BCLK_W;  // 64 bit slots per frame
  localparam int DELAY_AW     = 12;
  localparam int DELAY_DEPTH  = 2 ** DELAY_AW;
  localparam int DC_SHIFT     = 8;             // pole near 1 - 1/256

  localparam int APB_AW = 4;
  localparam int APB_DW = 32;

  // register map, one word each
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
  localparam logic [APB_AW-1:0] ADDR_DELAY  = 4'h4;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h8;
  localparam logic [APB_AW-1:0] ADDR_SAMPLE = 4'hC;

  typedef enum logic [1:0] {
    SRC_RAW   = 2'd0,
    SRC_DC    = 2'd1,
    SRC_DELAY = 2'd2,
    SRC_ECHO  = 2'd3   // dry plus half delayed
  } src_sel_e;

  // clamp a wide sum to the 16-bit audio range
  function automatic logic signed [AUDIO_W-1:0] sat_audio(input logic [SUM_W-1:0] v);
    logic [SUM_W-AUDIO_W:0] top;
    top = v[SUM_W-1:AUDIO_W-1];
    if (top == '0 || top == '1) begin
      return v[AUDIO_W-1:0];
    end else if (v[SUM_W-1]) begin
      return {1'b1, {(AUDIO_W-1){1'b0}}};
    end
    return {1'b0, {(AUDIO_W-1){1'b1}}};
  endfunction

endpackage

// ==== audio_ctrl_if.sv ====
`timescale 1ns/1ps

interface audio_ctrl_if import mic_echo_pkg::*; ();

  logic                mic_enable;
  src_sel_e            source_sel;
  logic [DELAY_AW-1:0] delay_samples;  // in frames
  logic [1:0]          spk_enable;     // bit 0 left, bit 1 right
  logic [AUDIO_W-1:0]  last_sample;
  logic                delay_full;

  // host side
  modport regs (
    output mic_enable, source_sel, delay_samples, spk_enable,
    input  last_sample, delay_full
  );

  // audio chain side
  modport datapath (
    input  mic_enable, source_sel, delay_samples, spk_enable,
    output last_sample, delay_full
  );

endinterface

// ==== i2s_mic_rx.sv ====
`timescale 1ns/1ps

module i2s_mic_rx import mic_echo_pkg::*; (
  input  logic               audio_clk,
  input  logic               rst_n,
  audio_ctrl_if.datapath     ctrl,
  input  logic               mic_data,
  output logic               bclk,
  output logic               lrcl,
  output logic [AUDIO_W-1:0] mic_sample,
  output logic               mic_valid
);

  logic [FRAME_W-1:0] frame_cnt;
  logic [SLOT_W-1:0]  slot;
  logic [BCLK_W-1:0]  phase;
  logic               frame_end;
  logic               rise_pt;
  logic               in_word;
  logic [AUDIO_W-1:0] shift_reg;

  assign slot  = frame_cnt[FRAME_W-1:BCLK_W];
  assign phase = frame_cnt[BCLK_W-1:0];

  assign frame_end = (frame_cnt == FRAME_W'(FRAME_CYCLES - 1));

  // edge on which bclk goes high
  assign rise_pt = (phase == BCLK_W'(BCLK_DIV / 2 - 1));

  // slots 1..16 of the left half carry the word
  assign in_word = (slot != '0) && (slot <= SLOT_W'(AUDIO_W));

  assign bclk = frame_cnt[BCLK_W-1];   // high in second half of each slot
  assign lrcl = frame_cnt[FRAME_W-1];  // low = left channel

  // free running frame counter
  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (frame_end) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // msb arrives first
  always_ff @(posedge audio_clk) begin
    if (rise_pt && in_word) begin
      shift_reg <= {shift_reg[AUDIO_W-2:0], mic_data};
    end
  end

  always_ff @(posedge audio_clk) begin
    if (frame_end) begin
      mic_sample <= shift_reg;  // word of the frame just ended
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      mic_valid <= 1'b0;
    end else begin
      mic_valid <= frame_end && ctrl.mic_enable;
    end
  end

endmodule

// ==== dc_blocker.sv ====
`timescale 1ns/1ps

module dc_blocker import mic_echo_pkg::*; (
  input  logic                      audio_clk,
  input  logic                      rst_n,
  input  logic signed [AUDIO_W-1:0] x_in,
  input  logic                      x_valid,
  output logic signed [AUDIO_W-1:0] y_out,
  output logic                      y_valid
);

  logic signed [AUDIO_W-1:0] x_prev;
  logic signed [AUDIO_W-1:0] y_prev;
  logic signed [SUM_W-1:0]   sum;
  logic signed [SUM_W-1:0]   leak;

  // slow decay of the previous output sets the corner frequency
  assign leak = SUM_W'(y_prev >>> DC_SHIFT);

  // y[n] = x[n] - x[n-1] + y[n-1] - y[n-1]/2^DC_SHIFT
  assign sum = SUM_W'(x_in) - SUM_W'(x_prev) + SUM_W'(y_prev) - leak;

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      x_prev  <= '0;
      y_prev  <= '0;
      y_valid <= 1'b0;
    end else begin
      y_valid <= x_valid;
      if (x_valid) begin
        x_prev <= x_in;
        y_prev <= sat_audio(sum);
      end
    end
  end

  assign y_out = y_prev;  // output register doubles as filter state

endmodule

// ==== echo_mixer.sv ====
`timescale 1ns/1ps

module echo_mixer import mic_echo_pkg::*; (
  input  logic               audio_clk,
  input  logic               rst_n,
  audio_ctrl_if.datapath     ctrl,
  input  logic [AUDIO_W-1:0] raw_in,
  input  logic [AUDIO_W-1:0] dc_in,
  input  logic               in_valid,
  output logic [AUDIO_W-1:0] audio_out,
  output logic               audio_valid
);

  logic [AUDIO_W-1:0]        mem [DELAY_DEPTH];
  logic [DELAY_AW-1:0]       wr_ptr;
  logic [DELAY_AW-1:0]       rd_addr;
  logic [DELAY_AW-1:0]       fill_cnt;
  logic [DELAY_AW-1:0]       delay_prev;
  logic                      full;
  logic                      rd_ok;      // history covered the delay at read time
  logic                      mix_go;
  logic [AUDIO_W-1:0]        rd_data;
  logic signed [AUDIO_W-1:0] delayed;
  logic signed [SUM_W-1:0]   echo_sum;
  logic [AUDIO_W-1:0]        mix;

  assign rd_addr = wr_ptr - ctrl.delay_samples;  // wraps around the ring
  assign full    = (fill_cnt >= ctrl.delay_samples);

  always_ff @(posedge audio_clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= dc_in;
      rd_data     <= mem[rd_addr];
    end
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      fill_cnt   <= '0;
      delay_prev <= '0;
      rd_ok      <= 1'b0;
      mix_go     <= 1'b0;
    end else begin
      delay_prev <= ctrl.delay_samples;
      mix_go     <= in_valid;
      if (ctrl.delay_samples != delay_prev) begin
        fill_cnt <= '0;  // new delay, refill before playing back
      end else if (in_valid && fill_cnt != '1) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
        rd_ok  <= full;
      end
    end
  end

  // raw_in and dc_in hold for the whole frame
  assign delayed  = rd_ok ? rd_data : '0;
  assign echo_sum = SUM_W'(signed'(dc_in)) + SUM_W'(delayed >>> 1);

  always_comb begin
    case (ctrl.source_sel)
      SRC_RAW:   mix = raw_in;
      SRC_DC:    mix = dc_in;
      SRC_DELAY: mix = delayed;
      default:   mix = sat_audio(echo_sum);
    endcase
  end

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      audio_out   <= '0;
      audio_valid <= 1'b0;
    end else begin
      audio_valid <= mix_go;
      if (mix_go) audio_out <= mix;
    end
  end

  assign ctrl.last_sample = audio_out;
  assign ctrl.delay_full  = full;

endmodule

// ==== pdm_modulator.sv ====
`timescale 1ns/1ps

module pdm_modulator import mic_echo_pkg::*; (
  input  logic                      audio_clk,
  input  logic                      rst_n,
  audio_ctrl_if.datapath            ctrl,
  input  logic signed [AUDIO_W-1:0] level,
  input  logic                      level_valid,
  output logic                      spk_l,
  output logic                      spk_r
);

  logic [AUDIO_W-1:0] level_ob;  // offset binary, 0 = most negative
  logic [AUDIO_W-1:0] acc;
  logic [AUDIO_W:0]   acc_sum;
  logic               pdm_bit;

  assign acc_sum = {1'b0, acc} + {1'b0, level_ob};

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      level_ob <= '0;
      acc      <= '0;
      pdm_bit  <= 1'b0;
    end else begin
      if (level_valid) begin
        level_ob <= {~level[AUDIO_W-1], level[AUDIO_W-2:0]};  // flip sign bit
      end
      acc     <= acc_sum[AUDIO_W-1:0];
      pdm_bit <= acc_sum[AUDIO_W];  // carry out is the density bit
    end
  end

  assign spk_l = pdm_bit & ctrl.spk_enable[0];
  assign spk_r = pdm_bit & ctrl.spk_enable[1];

endmodule

// ==== apb_audio_regs.sv ====
`timescale 1ns/1ps

module apb_audio_regs import mic_echo_pkg::*; (
  input  logic              audio_clk,
  input  logic              rst_n,
  audio_ctrl_if.regs        ctrl,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [APB_DW-1:0] pwdata,
  output logic [APB_DW-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic                mic_en;
  src_sel_e            src_sel;
  logic [1:0]          spk_en;
  logic [DELAY_AW-1:0] delay_reg;
  logic [DELAY_AW-1:0] delay_wdata;
  logic                access;
  logic                addr_hit;

  assign access      = psel & penable;  // access phase
  assign delay_wdata = pwdata[DELAY_AW-1:0];

  assign addr_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_DELAY) ||
                    (paddr == ADDR_STATUS) || (paddr == ADDR_SAMPLE);

  always_ff @(posedge audio_clk) begin
    if (!rst_n) begin
      mic_en    <= 1'b0;
      src_sel   <= SRC_RAW;
      spk_en    <= '0;
      delay_reg <= DELAY_AW'(1);
    end else if (access && pwrite) begin
      case (paddr)
        ADDR_CTRL: begin
          mic_en  <= pwdata[0];
          src_sel <= src_sel_e'(pwdata[2:1]);
          spk_en  <= pwdata[4:3];
        end
        ADDR_DELAY: begin
          // zero delay would read the slot being written
          delay_reg <= (delay_wdata == '0) ? DELAY_AW'(1) : delay_wdata;
        end
        default: ;  // status and sample are read only
      endcase
    end
  end

  // no wait states, read data valid during the access phase
  always_comb begin
    case (paddr)
      ADDR_CTRL:   prdata = APB_DW'({spk_en, src_sel, mic_en});
      ADDR_DELAY:  prdata = APB_DW'(delay_reg);
      ADDR_STATUS: prdata = APB_DW'(ctrl.delay_full);
      ADDR_SAMPLE: prdata = APB_DW'(signed'(ctrl.last_sample));  // sign extended
      default:     prdata = '0;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = access & ~addr_hit;

  assign ctrl.mic_enable    = mic_en;
  assign ctrl.source_sel    = src_sel;
  assign ctrl.spk_enable    = spk_en;
  assign ctrl.delay_samples = delay_reg;

endmodule

// ==== mic_echo_top.sv ====
`timescale 1ns/1ps

module mic_echo_top import mic_echo_pkg::*; (
  input  logic               audio_clk,
  input  logic               rst_n,
  // microphone
  input  logic               mic_data,
  output logic               bclk,
  output logic               lrcl,
  // speaker pins
  output logic               spk_l,
  output logic               spk_r,
  // processed stream
  output logic [AUDIO_W-1:0] audio_out,
  output logic               audio_valid,
  // APB slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [APB_AW-1:0]  paddr,
  input  logic [APB_DW-1:0]  pwdata,
  output logic [APB_DW-1:0]  prdata,
  output logic               pready,
  output logic               pslverr
);

  logic [AUDIO_W-1:0] mic_sample;
  logic               mic_valid;
  logic [AUDIO_W-1:0] dc_sample;
  logic               dc_valid;

  audio_ctrl_if ctrl ();

  i2s_mic_rx u_mic_rx (
    .audio_clk  (audio_clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl.datapath),
    .mic_data   (mic_data),
    .bclk       (bclk),
    .lrcl       (lrcl),
    .mic_sample (mic_sample),
    .mic_valid  (mic_valid)
  );

  dc_blocker u_dc_blocker (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .x_in      (mic_sample),
    .x_valid   (mic_valid),
    .y_out     (dc_sample),
    .y_valid   (dc_valid)
  );

  // 2 cycles behind dc_valid, 3 behind the frame wrap
  echo_mixer u_echo_mixer (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl.datapath),
    .raw_in      (mic_sample),
    .dc_in       (dc_sample),
    .in_valid    (dc_valid),
    .audio_out   (audio_out),
    .audio_valid (audio_valid)
  );

  pdm_modulator u_pdm (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl.datapath),
    .level       (audio_out),
    .level_valid (audio_valid),
    .spk_l       (spk_l),
    .spk_r       (spk_r)
  );

  apb_audio_regs u_regs (
    .audio_clk (audio_clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl.regs),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr)
  );

endmodule

// ==== tb_mic_echo.sv ====
`timescale 1ns/1ps

module tb_mic_echo import mic_echo_pkg::*; ();

  logic              audio_clk;
  logic              rst_n;
  logic              mic_data = 1'b0;
  logic              bclk;
  logic              lrcl;
  logic              spk_l;
  logic              spk_r;
  logic [AUDIO_W-1:0] audio_out;
  logic              audio_valid;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  int checks = 0;
  int errors = 0;
  int cyc = 0;
  bit aborted = 1'b0;  // stimulus stops after a timeout

  // microphone model state
  logic [AUDIO_W-1:0] tx_word = '0;          // word the main flow wants sent
  logic [AUDIO_W-1:0] cur_word = '0;         // word on the wire this frame
  logic [AUDIO_W-1:0] last_frame_word = '0;  // word of the frame just ended
  logic               next_bit = 1'b0;
  logic               bclk_last = 1'b0;
  logic               lrcl_last = 1'b0;
  int slot = 0;
  int wrap_cyc = 0;
  int wrap_count = 0;
  int valid_count = 0;

  // register mirror and reference models
  logic [1:0] mir_src = 2'd0;
  int mir_delay = 1;
  int mdl_fill = 0;
  int dc_xp = 0;
  int dc_yp = 0;
  int dc_hist[$];
  int last_exp = 0;

  mic_echo_top dut (
    .audio_clk   (audio_clk),
    .rst_n       (rst_n),
    .mic_data    (mic_data),
    .bclk        (bclk),
    .lrcl        (lrcl),
    .spk_l       (spk_l),
    .spk_r       (spk_r),
    .audio_out   (audio_out),
    .audio_valid (audio_valid),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  initial begin
    audio_clk = 1'b0;
    forever #4 audio_clk = ~audio_clk;
  end

  always @(posedge audio_clk) begin
    cyc      <= cyc + 1;
    mic_data <= next_bit;  // mic drives after the falling bclk
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic abort_run(input string why);
    errors++;
    aborted = 1'b1;
    $display("ERROR: %s", why);
  endtask

  function automatic int sat16(input int v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
  endfunction

  // reference for one processed frame
  task automatic score_output();
    int x;
    int dl;
    int e;
    int n;
    x = int'($signed(last_frame_word));
    dc_yp = sat16(x - dc_xp + dc_yp - (dc_yp >>> DC_SHIFT));
    dc_xp = x;
    n = dc_hist.size();
    dl = (mdl_fill >= mir_delay) ? dc_hist[n - mir_delay] : 0;
    dc_hist.push_back(dc_yp);
    mdl_fill++;
    case (mir_src)
      2'd0:    e = x;
      2'd1:    e = dc_yp;
      2'd2:    e = dl;
      default: e = sat16(dc_yp + (dl >>> 1));
    endcase
    valid_count++;
    check_value(cyc - wrap_cyc, 3, "audio_valid latency after frame wrap");
    check_value({16'h0, audio_out}, {16'h0, e[15:0]}, "audio_out");
    last_exp = e;
  endtask

  // frame tracking, mic bit stream and output scoreboard
  always @(negedge audio_clk) begin
    if (rst_n === 1'b1) begin
      if (lrcl_last === 1'b1 && lrcl === 1'b0) begin
        if (wrap_count > 0) begin
          check_value(cyc - wrap_cyc, FRAME_CYCLES, "lrcl frame period");
          check_value(slot + 1, FRAME_CYCLES / BCLK_DIV, "bclk periods per frame");
        end
        last_frame_word = cur_word;
        slot            = 0;
        wrap_cyc        = cyc;
        wrap_count++;
      end else if (bclk_last === 1'b1 && bclk === 1'b0) begin
        slot++;
        if (slot == 1) cur_word = tx_word;
      end
      next_bit = (slot >= 1 && slot <= AUDIO_W) ? cur_word[AUDIO_W - slot] : 1'b0;
      if (audio_valid === 1'b1) score_output();
    end
    lrcl_last = lrcl;
    bclk_last = bclk;
  end

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int guard;
    int nd;
    @(posedge audio_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge audio_clk);
    penable <= 1'b1;
    guard = 0;
    do begin
      @(posedge audio_clk);
      guard++;
    end while (pready !== 1'b1 && guard < 16);
    if (guard >= 16) abort_run("pready never came during APB access");
    rdata = prdata;
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    if (wr && addr == ADDR_CTRL) mir_src = wdata[2:1];
    if (wr && addr == ADDR_DELAY) begin
      nd = (wdata[11:0] == 0) ? 1 : int'(wdata[11:0]);
      if (nd != mir_delay) mdl_fill = 0;  // ring refills after a change
      mir_delay = nd;
    end
  endtask

  task automatic wait_wraps(input int n);
    int target;
    int guard;
    target = wrap_count + n;
    guard = 0;
    while (wrap_count < target && guard < n * FRAME_CYCLES + 64) begin
      @(posedge audio_clk);
      guard++;
    end
    if (wrap_count < target) abort_run("frame wrap did not come");
  endtask

  task automatic send_sample(input logic [15:0] s);
    int n0;
    int guard;
    if (!(slot == 0 && lrcl === 1'b0)) wait_wraps(1);
    tx_word = s;
    wait_wraps(1);
    n0 = valid_count;
    guard = 0;
    while (valid_count == n0 && guard < 3 * FRAME_CYCLES) begin
      @(posedge audio_clk);
      guard++;
    end
    if (valid_count == n0) abort_run("audio_valid did not come within 3 frames");
  endtask

  task automatic count_pdm();
    int ones_l;
    int ones_r;
    int diff;
    ones_l = 0;
    ones_r = 0;
    repeat (4) @(posedge audio_clk);
    repeat (65536) begin
      @(posedge audio_clk);
      ones_l += spk_l;
      ones_r += spk_r;
    end
    diff = ones_l - (last_exp + 32768);
    if (diff < 0) diff = -diff;
    check_value(diff <= 1, 1, "pdm density on spk_l");
    check_value(ones_r, 0, "spk_r with enable clear");
  endtask

  initial begin
    int fd;
    int rc;
    int n0;
    string line;
    string op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    logic err;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (8) @(posedge audio_clk);
    rst_n <= 1'b1;
    @(posedge audio_clk);
    fd = $fopen("mic_echo_stimulus.txt", "r");
    if (fd == 0) abort_run("cannot open mic_echo_stimulus.txt");
    while (!aborted && !$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 0) begin
        op = line.substr(0, 0);
        a = '0;
        b = '0;
        if (line.len() > 1) rc = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        case (op)
          "W": apb_access(1'b1, a[3:0], b, rd, err);
          "R": begin
            apb_access(1'b0, a[3:0], '0, rd, err);
            check_value(rd, b, $sformatf("readback of address %h", a[3:0]));
            check_value(err, 0, "pslverr on mapped address");
          end
          "E": begin
            // odd byte address, never a register
            apb_access(1'b0, a[3:0] | 4'h1, '0, rd, err);
            check_value(err, 1, "pslverr on unmapped address");
          end
          "X": send_sample(a[15:0]);
          "I": begin
            n0 = valid_count;  // mic off, nothing may come out
            wait_wraps(a);
            repeat (8) @(posedge audio_clk);
            check_value(valid_count, n0, "audio_valid count with mic disabled");
          end
          "S": begin
            apb_access(1'b0, ADDR_STATUS, '0, rd, err);
            check_value(rd, (mdl_fill >= mir_delay) ? 1 : 0, "delay_full status");
          end
          "C": begin
            apb_access(1'b0, ADDR_SAMPLE, '0, rd, err);
            check_value(rd, 32'(last_exp), "SAMPLE register");
          end
          "P": count_pdm();
          "#", "\n", " ": ;
          default: abort_run($sformatf("unknown stimulus line: %s", line));
        endcase
      end
    end
    if (fd != 0) $fclose(fd);
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== mic_echo_stimulus.txt ====
# op then hex fields: W addr data, R addr expect, E addr, X mic word, I frames
# S status check, C sample register check, P pdm density check
R 0 0
R 4 1
S
R C 0
E 10
W 4 0
R 4 1
W 4 abc
R 4 abc
W 0 1e
R 0 1e
W 0 0
R 0 0
I 2
W 0 1
X 1234
X 8000
X 7fff
X fedc
W 0 3
X 0400
X 0400
X 0400
X 7fff
X 8000
X 7fff
W 4 5
W 0 5
X 0100
X 0200
S
X 0300
X 0400
X 0500
X 0600
X 0700
S
W 0 7
X 7000
X 7000
X 7fff
X 8000
S
C
W 0 8
C
P

// ==== mic_echo.f ====
mic_echo_pkg.sv
audio_ctrl_if.sv
i2s_mic_rx.sv
dc_blocker.sv
echo_mixer.sv
pdm_modulator.sv
apb_audio_regs.sv
mic_echo_top.sv
tb_mic_echo.sv
